/* rtl/p2r_pkg.sv */
package p2r_pkg;

    // ====================
    // arithmetic constants
    // ====================

    // dilithium modulus q = 2^23 - 2^13 + 1
    localparam logic [22:0] DILITHIUM_Q = 23'd8380417;

    // stored coefficient width, msb is always zero
    localparam int COEF_W = 24;
    // bits dropped by power2round
    localparam int D_BITS = 13;
    localparam int T1_W = 10;
    localparam int T0_W = 13;

    // coefficients handled per cycle
    localparam int LANES = 8;

    // ====================
    // address widths
    // ====================

    localparam int MEM_ADDR_W = 12;
    localparam int SK_ADDR_W = 12;
    localparam int PK_ADDR_W = 8;

    // 256 coefficients x 13 bits / 64 bits per sk word
    localparam int SK_WORDS_PER_POLY = 52;

    // four coefficients per memory word, coefficient 0 in the low bits
    typedef logic [3:0][COEF_W-1:0] mem_word_t;

    // one row of eight lanes, lane 0 in the low bits
    typedef logic [LANES-1:0][T0_W-1:0] t0_group_t;
    typedef logic [LANES-1:0][T1_W-1:0] t1_row_t;

    typedef struct packed {
        logic                  rd_en;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

/* rtl/power2round_lane.sv */
`timescale 1ns/1ps

module power2round_lane (
    input  logic [p2r_pkg::COEF_W-1:0] r,
    output logic [p2r_pkg::T1_W-1:0]   r1,
    output logic [p2r_pkg::T0_W-1:0]   r0_enc
);

    // 2^(d-1) and 2^(d-1) - 1
    localparam logic [p2r_pkg::COEF_W-1:0] HALF = 1 << (p2r_pkg::D_BITS - 1);
    localparam logic [p2r_pkg::COEF_W-1:0] ROUND_OFS = (1 << (p2r_pkg::D_BITS - 1)) - 1;

    logic [p2r_pkg::COEF_W-1:0] r_round;
    logic [p2r_pkg::COEF_W-1:0] r1_full;
    logic [p2r_pkg::COEF_W-1:0] r0_enc_full;

    always_comb begin
        // r < q < 2^23, so the rounding add cannot carry out of 24 bits
        r_round = r + ROUND_OFS;
        r1_full = r_round >> p2r_pkg::D_BITS;
        // 2^12 - r0 with r0 = r - r1*2^13
        // true value lies in [0, 2^13), so the low bits are exact
        r0_enc_full = HALF + (r1_full << p2r_pkg::D_BITS) - r;
    end

    // r1 never exceeds 1023 for r < q
    assign r1 = r1_full[p2r_pkg::T1_W-1:0];
    assign r0_enc = r0_enc_full[p2r_pkg::T0_W-1:0];

endmodule

/* rtl/sk_pack_buffer.sv */
`timescale 1ns/1ps

module sk_pack_buffer (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic                 in_valid,
    input  p2r_pkg::t0_group_t   in_group,
    output logic                 almost_full,
    output logic                 out_valid,
    output logic [63:0]          out_data
);

    localparam int GROUP_W = p2r_pkg::LANES * p2r_pkg::T0_W;
    localparam int BUF_W = 384;
    localparam int OUT_W = 64;
    localparam int FILL_W = $clog2(BUF_W + 1);
    // room left for three more groups
    localparam int AFULL_LEVEL = BUF_W - 3 * GROUP_W;

    logic [BUF_W-1:0]  store;
    logic [FILL_W-1:0] fill;
    logic [BUF_W-1:0]  kept;
    logic [FILL_W-1:0] kept_fill;
    logic [BUF_W-1:0]  keep_mask;
    logic [BUF_W-1:0]  incoming;

    // oldest bits sit at the bottom of the store
    assign out_valid = fill >= FILL_W'(OUT_W);
    assign out_data = store[OUT_W-1:0];
    assign almost_full = fill > FILL_W'(AFULL_LEVEL);

    always_comb begin
        if (out_valid) begin
            kept = store >> OUT_W;
            kept_fill = fill - FILL_W'(OUT_W);
        end else begin
            kept = store;
            kept_fill = fill;
        end
        // bits above the fill level are don't care, mask them off
        keep_mask = ~({BUF_W{1'b1}} << kept_fill);
        incoming = BUF_W'(in_group) << kept_fill;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fill <= '0;
        end else if (zeroize) begin
            fill <= '0;
        end else if (in_valid) begin
            fill <= kept_fill + FILL_W'(GROUP_W);
        end else begin
            fill <= kept_fill;
        end
    end

    // secret t0 bits are wiped on zeroize
    always_ff @(posedge clk) begin
        if (zeroize) begin
            store <= '0;
        end else begin
            store <= (kept & keep_mask) | (in_valid ? incoming : '0);
        end
    end

    // the controller's read throttle must leave room for every group in flight
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        in_valid |-> (int'(kept_fill) + GROUP_W <= BUF_W)
    );

endmodule

/* rtl/power2round_ctrl.sv */
`timescale 1ns/1ps

module power2round_ctrl #(
    parameter int DILITHIUM_K = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             enable,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]   src_base_addr,
    input  logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_dest_base_addr,
    input  logic                             r_valid,
    input  logic                             sk_valid,
    input  logic                             almost_full,
    output p2r_pkg::mem_req_t                mem_a_rd_req,
    output p2r_pkg::mem_req_t                mem_b_rd_req,
    output logic                             skmem_wren,
    output logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_a_addr,
    output logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_b_addr,
    output logic                             pk_t1_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]    pk_t1_wr_addr,
    output logic                             done
);

    localparam int AW = p2r_pkg::MEM_ADDR_W;
    localparam int SW = p2r_pkg::SK_ADDR_W;
    localparam int ROWS_PER_POLY = 256 / p2r_pkg::LANES;
    localparam int TOTAL_ROWS = DILITHIUM_K * ROWS_PER_POLY;
    localparam int TOTAL_SK = DILITHIUM_K * p2r_pkg::SK_WORDS_PER_POLY;
    localparam int ROW_CNT_W = $clog2(TOTAL_ROWS + 1);
    localparam int SK_CNT_W = $clog2(TOTAL_SK + 1);

    logic                            busy;
    logic                            start;
    logic                            rd_issue;
    logic                            last_sk;
    logic [ROW_CNT_W-1:0]            rd_cnt;
    logic [SK_CNT_W-1:0]             sk_cnt;
    logic [p2r_pkg::PK_ADDR_W-1:0]   pk_cnt;
    logic [AW-1:0]                   src_base_q;
    logic [SW-1:0]                   sk_base_q;
    logic [AW-1:0]                   rd_addr;

    assign start = enable && !busy;
    // only read while the pack buffer can still absorb everything in flight
    assign rd_issue = busy && (rd_cnt != ROW_CNT_W'(TOTAL_ROWS)) && !almost_full;
    assign last_sk = sk_valid && (sk_cnt == SK_CNT_W'(TOTAL_SK - 1));
    // each row spans two memory words
    assign rd_addr = src_base_q + AW'({rd_cnt, 1'b0});

    // ====================
    // run state
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            src_base_q <= '0;
            sk_base_q <= '0;
        end else if (zeroize) begin
            busy <= 1'b0;
            done <= 1'b0;
            src_base_q <= '0;
            sk_base_q <= '0;
        end else begin
            done <= last_sk;
            if (start) begin
                busy <= 1'b1;
                src_base_q <= src_base_addr;
                sk_base_q <= skmem_dest_base_addr;
            end else if (last_sk) begin
                busy <= 1'b0;
            end
        end
    end

    // ====================
    // counters and reads
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_cnt <= '0;
            sk_cnt <= '0;
            pk_cnt <= '0;
            mem_a_rd_req <= '0;
            mem_b_rd_req <= '0;
        end else if (zeroize) begin
            rd_cnt <= '0;
            sk_cnt <= '0;
            pk_cnt <= '0;
            mem_a_rd_req <= '0;
            mem_b_rd_req <= '0;
        end else begin
            if (start) begin
                rd_cnt <= '0;
                sk_cnt <= '0;
                pk_cnt <= '0;
            end else begin
                if (rd_issue) rd_cnt <= rd_cnt + 1'b1;
                if (sk_valid) sk_cnt <= sk_cnt + 1'b1;
                if (r_valid) pk_cnt <= pk_cnt + 1'b1;
            end
            mem_a_rd_req.rd_en <= rd_issue;
            mem_a_rd_req.addr <= rd_addr;
            mem_b_rd_req.rd_en <= rd_issue;
            mem_b_rd_req.addr <= rd_addr + 1'b1;
        end
    end

    // a word low half at base + 2j, high half at base + 2j + 1
    assign skmem_wren = sk_valid;
    assign skmem_a_addr = sk_base_q + SW'({sk_cnt, 1'b0});
    assign skmem_b_addr = skmem_a_addr + 1'b1;

    assign pk_t1_wren = r_valid;
    assign pk_t1_wr_addr = pk_cnt;

    // starts are only accepted from idle
    a_no_enable_busy: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        enable |-> !busy
    );

    // a read request always belongs to a run
    a_no_read_idle: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        mem_a_rd_req.rd_en |-> busy
    );

endmodule

/* rtl/power2round_top.sv */
`timescale 1ns/1ps

module power2round_top #(
    parameter int DILITHIUM_K = 4
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             enable,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]   src_base_addr,
    input  logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_dest_base_addr,
    input  p2r_pkg::mem_word_t               mem_rd_data_a,
    input  p2r_pkg::mem_word_t               mem_rd_data_b,
    output p2r_pkg::mem_req_t                mem_a_rd_req,
    output p2r_pkg::mem_req_t                mem_b_rd_req,
    output logic                             skmem_wren,
    output logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_a_addr,
    output logic [31:0]                      skmem_a_data,
    output logic [p2r_pkg::SK_ADDR_W-1:0]    skmem_b_addr,
    output logic [31:0]                      skmem_b_data,
    output logic                             pk_t1_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]    pk_t1_wr_addr,
    output p2r_pkg::t1_row_t                 pk_t1_wrdata,
    output logic                             done
);

    localparam logic [p2r_pkg::COEF_W-1:0] Q_EXT = p2r_pkg::DILITHIUM_Q;

    logic                                             rd_valid_d;
    logic                                             coef_valid;
    logic                                             r_valid;
    logic [p2r_pkg::LANES-1:0][p2r_pkg::COEF_W-1:0]   coef_reg;
    logic [p2r_pkg::LANES-1:0]                        coef_ok;
    p2r_pkg::t1_row_t                                 t1_next;
    p2r_pkg::t1_row_t                                 t1_reg;
    p2r_pkg::t0_group_t                               t0_next;
    p2r_pkg::t0_group_t                               t0_reg;
    logic                                             almost_full;
    logic                                             sk_valid;
    logic [63:0]                                      sk_word;

    // ====================
    // valid pipeline
    // ====================

    // memory data lands one cycle after the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_d <= 1'b0;
            coef_valid <= 1'b0;
            r_valid <= 1'b0;
        end else if (zeroize) begin
            rd_valid_d <= 1'b0;
            coef_valid <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            rd_valid_d <= mem_a_rd_req.rd_en;
            coef_valid <= rd_valid_d;
            r_valid <= coef_valid;
        end
    end

    // port a carries lanes 0..3, port b lanes 4..7
    always_ff @(posedge clk) begin
        if (zeroize) begin
            coef_reg <= '0;
        end else if (rd_valid_d) begin
            coef_reg <= {mem_rd_data_b, mem_rd_data_a};
        end
    end

    for (genvar i = 0; i < p2r_pkg::LANES; i++) begin : g_lane
        power2round_lane u_lane (
            .r      (coef_reg[i]),
            .r1     (t1_next[i]),
            .r0_enc (t0_next[i])
        );
        assign coef_ok[i] = coef_reg[i] < Q_EXT;
    end

    always_ff @(posedge clk) begin
        if (zeroize) begin
            t1_reg <= '0;
            t0_reg <= '0;
        end else if (coef_valid) begin
            t1_reg <= t1_next;
            t0_reg <= t0_next;
        end
    end

    assign pk_t1_wrdata = t1_reg;

    sk_pack_buffer u_sk_pack_buffer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .in_valid    (r_valid),
        .in_group    (t0_reg),
        .almost_full (almost_full),
        .out_valid   (sk_valid),
        .out_data    (sk_word)
    );

    assign skmem_a_data = sk_word[31:0];
    assign skmem_b_data = sk_word[63:32];

    power2round_ctrl #(
        .DILITHIUM_K (DILITHIUM_K)
    ) u_power2round_ctrl (
        .clk                  (clk),
        .reset_n              (reset_n),
        .zeroize              (zeroize),
        .enable               (enable),
        .src_base_addr        (src_base_addr),
        .skmem_dest_base_addr (skmem_dest_base_addr),
        .r_valid              (r_valid),
        .sk_valid             (sk_valid),
        .almost_full          (almost_full),
        .mem_a_rd_req         (mem_a_rd_req),
        .mem_b_rd_req         (mem_b_rd_req),
        .skmem_wren           (skmem_wren),
        .skmem_a_addr         (skmem_a_addr),
        .skmem_b_addr         (skmem_b_addr),
        .pk_t1_wren           (pk_t1_wren),
        .pk_t1_wr_addr        (pk_t1_wr_addr),
        .done                 (done)
    );

    // source memory must hold reduced coefficients
    a_coef_in_range: assert property (
        @(posedge clk) disable iff (!reset_n || zeroize)
        coef_valid |-> &coef_ok
    );

endmodule

/* rtl/coef_mem.sv */
`timescale 1ns/1ps

module coef_mem #(
    parameter int DEPTH = 512
) (
    input  logic                             clk,
    input  logic                             we,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]   waddr,
    input  p2r_pkg::mem_word_t               wdata,
    input  p2r_pkg::mem_req_t                rd_req_a,
    input  p2r_pkg::mem_req_t                rd_req_b,
    output p2r_pkg::mem_word_t               rd_data_a,
    output p2r_pkg::mem_word_t               rd_data_b
);

    localparam int IDX_W = $clog2(DEPTH);

    p2r_pkg::mem_word_t mem [DEPTH];

    // single write port used by the loader
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[IDX_W-1:0]] <= wdata;
        end
    end

    // two read ports, one cycle latency, output holds when idle
    always_ff @(posedge clk) begin
        if (rd_req_a.rd_en) begin
            rd_data_a <= mem[rd_req_a.addr[IDX_W-1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req_b.rd_en) begin
            rd_data_b <= mem[rd_req_b.addr[IDX_W-1:0]];
        end
    end

endmodule

/* rtl/p2r_subsys.sv */
`timescale 1ns/1ps

module p2r_subsys #(
    parameter int DILITHIUM_K = 4,
    parameter int MEM_DEPTH = 512
) (
    input  logic                                          clk,
    input  logic                                          reset_n,
    input  logic                                          zeroize,
    input  logic                                          enable,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]                src_base_addr,
    input  logic [p2r_pkg::SK_ADDR_W-1:0]                 skmem_dest_base_addr,
    input  logic                                          load_en,
    input  logic [p2r_pkg::MEM_ADDR_W-1:0]                load_addr,
    input  logic [4*p2r_pkg::COEF_W-1:0]                  load_data,
    output logic                                          skmem_wren,
    output logic [p2r_pkg::SK_ADDR_W-1:0]                 skmem_a_addr,
    output logic [31:0]                                   skmem_a_data,
    output logic [p2r_pkg::SK_ADDR_W-1:0]                 skmem_b_addr,
    output logic [31:0]                                   skmem_b_data,
    output logic                                          pk_t1_wren,
    output logic [p2r_pkg::PK_ADDR_W-1:0]                 pk_t1_wr_addr,
    output logic [p2r_pkg::LANES*p2r_pkg::T1_W-1:0]       pk_t1_wrdata,
    output logic                                          done
);

    p2r_pkg::mem_req_t  mem_a_rd_req;
    p2r_pkg::mem_req_t  mem_b_rd_req;
    p2r_pkg::mem_word_t mem_rd_data_a;
    p2r_pkg::mem_word_t mem_rd_data_b;

    // source polynomials, filled through the load port
    coef_mem #(
        .DEPTH (MEM_DEPTH)
    ) u_coef_mem (
        .clk       (clk),
        .we        (load_en),
        .waddr     (load_addr),
        .wdata     (load_data),
        .rd_req_a  (mem_a_rd_req),
        .rd_req_b  (mem_b_rd_req),
        .rd_data_a (mem_rd_data_a),
        .rd_data_b (mem_rd_data_b)
    );

    power2round_top #(
        .DILITHIUM_K (DILITHIUM_K)
    ) u_power2round_top (
        .clk                  (clk),
        .reset_n              (reset_n),
        .zeroize              (zeroize),
        .enable               (enable),
        .src_base_addr        (src_base_addr),
        .skmem_dest_base_addr (skmem_dest_base_addr),
        .mem_rd_data_a        (mem_rd_data_a),
        .mem_rd_data_b        (mem_rd_data_b),
        .mem_a_rd_req         (mem_a_rd_req),
        .mem_b_rd_req         (mem_b_rd_req),
        .skmem_wren           (skmem_wren),
        .skmem_a_addr         (skmem_a_addr),
        .skmem_a_data         (skmem_a_data),
        .skmem_b_addr         (skmem_b_addr),
        .skmem_b_data         (skmem_b_data),
        .pk_t1_wren           (pk_t1_wren),
        .pk_t1_wr_addr        (pk_t1_wr_addr),
        .pk_t1_wrdata         (pk_t1_wrdata),
        .done                 (done)
    );

endmodule

/* dv/tb_p2r_subsys.sv */
`timescale 1ns/1ps

module tb_p2r_subsys;

    localparam int K = 4;
    localparam int MEM_DEPTH = 512;
    localparam int ROWS = K * 32;
    localparam int SK_WORDS = K * p2r_pkg::SK_WORDS_PER_POLY;
    localparam int T1W = p2r_pkg::T1_W;
    localparam int T0W = p2r_pkg::T0_W;
    localparam int unsigned Q = p2r_pkg::DILITHIUM_Q;
    // edge, random, bases and two runs in the zeroize test
    localparam int NUM_RUNS = 5;
    localparam int RUN_LIMIT = 300 * K;
    localparam int WATCHDOG_CYCLES = 300 * K * NUM_RUNS + 1000;

    typedef logic [p2r_pkg::COEF_W-1:0] coef_t;
    typedef logic [p2r_pkg::MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [p2r_pkg::SK_ADDR_W-1:0] sk_addr_t;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic enable;
    mem_addr_t src_base_addr;
    sk_addr_t skmem_dest_base_addr;
    logic load_en;
    mem_addr_t load_addr;
    logic [4*p2r_pkg::COEF_W-1:0] load_data;
    logic skmem_wren;
    sk_addr_t skmem_a_addr;
    logic [31:0] skmem_a_data;
    sk_addr_t skmem_b_addr;
    logic [31:0] skmem_b_data;
    logic pk_t1_wren;
    logic [p2r_pkg::PK_ADDR_W-1:0] pk_t1_wr_addr;
    logic [p2r_pkg::LANES*p2r_pkg::T1_W-1:0] pk_t1_wrdata;
    logic done;

    // source polynomials, coefficient c of poly p at p*256 + c
    coef_t coefs [K*256];
    p2r_pkg::t1_row_t exp_t1_q[$];
    logic [63:0] exp_sk_q[$];

    // captured writes
    p2r_pkg::t1_row_t pk_data_q[$];
    sk_addr_t pk_addr_q[$];
    sk_addr_t ska_addr_q[$];
    sk_addr_t skb_addr_q[$];
    logic [31:0] ska_data_q[$];
    logic [31:0] skb_data_q[$];
    int done_cnt;
    int done_cycle;
    int last_sk_cycle;
    int pk_at_done;
    int cycle;

    p2r_subsys #(
        .DILITHIUM_K (K),
        .MEM_DEPTH   (MEM_DEPTH)
    ) u_p2r_subsys (
        .clk                  (clk),
        .reset_n              (reset_n),
        .zeroize              (zeroize),
        .enable               (enable),
        .src_base_addr        (src_base_addr),
        .skmem_dest_base_addr (skmem_dest_base_addr),
        .load_en              (load_en),
        .load_addr            (load_addr),
        .load_data            (load_data),
        .skmem_wren           (skmem_wren),
        .skmem_a_addr         (skmem_a_addr),
        .skmem_a_data         (skmem_a_data),
        .skmem_b_addr         (skmem_b_addr),
        .skmem_b_data         (skmem_b_data),
        .pk_t1_wren           (pk_t1_wren),
        .pk_t1_wr_addr        (pk_t1_wr_addr),
        .pk_t1_wrdata         (pk_t1_wrdata),
        .done                 (done)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // monitor and checks
    // ====================

    // outputs are sampled at the falling edge, half a cycle after they settle
    initial cycle = 0;
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (skmem_wren) begin
            ska_addr_q.push_back(skmem_a_addr);
            ska_data_q.push_back(skmem_a_data);
            skb_addr_q.push_back(skmem_b_addr);
            skb_data_q.push_back(skmem_b_data);
            last_sk_cycle = cycle;
        end
        if (pk_t1_wren) begin
            pk_data_q.push_back(pk_t1_wrdata);
            pk_addr_q.push_back(sk_addr_t'(pk_t1_wr_addr));
        end
        if (done) begin
            done_cnt = done_cnt + 1;
            done_cycle = cycle;
            pk_at_done = pk_data_q.size();
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_t1(input string name, input p2r_pkg::t1_row_t exp,
                            input p2r_pkg::t1_row_t act);
        if (exp !== act) begin
            report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_sk(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input sk_addr_t exp, input sk_addr_t act);
        if (exp !== act) begin
            report_failure($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // ====================
    // reference model
    // ====================

    // centered remainder mod 2^13, then t0 stored as 2^12 - r0
    function automatic void split_coef(input coef_t r, output logic [T1W-1:0] r1,
                                       output logic [T0W-1:0] enc);
        int rv;
        int r0;
        rv = int'(r);
        r0 = rv % 8192;
        if (r0 > 4096) begin
            r0 = r0 - 8192;
        end
        r1 = T1W'((rv - r0) / 8192);
        enc = T0W'(4096 - r0);
    endfunction

    task automatic build_expected();
        logic [255:0] acc;
        int fill;
        p2r_pkg::t1_row_t row;
        p2r_pkg::t0_group_t grp;
        logic [T1W-1:0] r1;
        logic [T0W-1:0] enc;
        exp_t1_q.delete();
        exp_sk_q.delete();
        acc = '0;
        fill = 0;
        for (int g = 0; g < ROWS; g++) begin
            for (int i = 0; i < p2r_pkg::LANES; i++) begin
                split_coef(coefs[g*8+i], r1, enc);
                row[i] = r1;
                grp[i] = enc;
            end
            exp_t1_q.push_back(row);
            // bit stream grows upward, words are cut from its low end
            acc = acc | (256'(grp) << fill);
            fill = fill + 104;
            while (fill >= 64) begin
                exp_sk_q.push_back(acc[63:0]);
                acc = acc >> 64;
                fill = fill - 64;
            end
        end
    endtask

    // ====================
    // stimulus helpers
    // ====================

    task automatic drive_step();
        @(posedge clk);
        #1;
    endtask

    task automatic fill_random_polys();
        for (int n = 0; n < K * 256; n++) begin
            coefs[n] = coef_t'($urandom % Q);
        end
    endtask

    // poly 0 cycles through rounding boundaries, the rest is random
    task automatic fill_edge_polys();
        int edge_vals [16];
        edge_vals = '{0, 1, 4095, 4096, 4097, 8191, 8192, 8193, 12288, 12289,
                      4194304, 4198400, 8376320, 8376321, 8380415, 8380416};
        fill_random_polys();
        for (int c = 0; c < 256; c++) begin
            coefs[c] = coef_t'(edge_vals[(c + c / 16) % 16]);
        end
    endtask

    // row g sits at base + 2g (lanes 0..3) and base + 2g + 1 (lanes 4..7)
    task automatic load_polys(input mem_addr_t base);
        for (int g = 0; g < ROWS; g++) begin
            for (int h = 0; h < 2; h++) begin
                drive_step();
                load_en = 1'b1;
                load_addr = base + mem_addr_t'(2 * g + h);
                for (int j = 0; j < 4; j++) begin
                    load_data[j*p2r_pkg::COEF_W +: p2r_pkg::COEF_W] = coefs[g*8 + h*4 + j];
                end
            end
        end
        drive_step();
        load_en = 1'b0;
    endtask

    task automatic clear_captures();
        pk_data_q.delete();
        pk_addr_q.delete();
        ska_addr_q.delete();
        skb_addr_q.delete();
        ska_data_q.delete();
        skb_data_q.delete();
        done_cnt = 0;
        done_cycle = 0;
        last_sk_cycle = 0;
        pk_at_done = 0;
    endtask

    task automatic start_run(input mem_addr_t src, input sk_addr_t dst);
        clear_captures();
        drive_step();
        src_base_addr = src;
        skmem_dest_base_addr = dst;
        enable = 1'b1;
        drive_step();
        enable = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (done_cnt == 0 && n < RUN_LIMIT) begin
            drive_step();
            n++;
        end
        if (done_cnt == 0) begin
            report_failure("done strobe did not arrive within the run limit");
        end
        // extra cycles catch stray writes or a second done
        repeat (10) drive_step();
    endtask

    task automatic compare_results(input string name, input sk_addr_t dst);
        if (pk_data_q.size() != ROWS) begin
            report_failure($sformatf("%s saw %0d pk rows instead of %0d",
                                     name, pk_data_q.size(), ROWS));
        end
        if (ska_data_q.size() != SK_WORDS) begin
            report_failure($sformatf("%s saw %0d sk word pairs instead of %0d",
                                     name, ska_data_q.size(), SK_WORDS));
        end
        for (int g = 0; g < ROWS; g++) begin
            check_t1($sformatf("%s pk row %0d", name, g), exp_t1_q[g], pk_data_q[g]);
            check_addr($sformatf("%s pk addr %0d", name, g), sk_addr_t'(g), pk_addr_q[g]);
        end
        for (int j = 0; j < SK_WORDS; j++) begin
            check_sk($sformatf("%s sk a %0d", name, j), exp_sk_q[j][31:0], ska_data_q[j]);
            check_sk($sformatf("%s sk b %0d", name, j), exp_sk_q[j][63:32], skb_data_q[j]);
            check_addr($sformatf("%s sk a addr %0d", name, j),
                       dst + sk_addr_t'(2 * j), ska_addr_q[j]);
            check_addr($sformatf("%s sk b addr %0d", name, j),
                       dst + sk_addr_t'(2 * j + 1), skb_addr_q[j]);
        end
        if (done_cnt != 1) begin
            report_failure($sformatf("%s saw %0d done pulses instead of one", name, done_cnt));
        end
        if (done_cycle != last_sk_cycle + 1) begin
            report_failure($sformatf("%s done did not follow the last sk word", name));
        end
        if (pk_at_done != ROWS) begin
            report_failure($sformatf("%s pk rows were still pending at done", name));
        end
    endtask

    // ====================
    // directed tests
    // ====================

    task automatic test_idle();
        clear_captures();
        repeat (50) drive_step();
        if (pk_data_q.size() != 0 || ska_data_q.size() != 0 || done_cnt != 0) begin
            report_failure("outputs were active while idle after reset");
        end
    endtask

    task automatic test_edge();
        fill_edge_polys();
        load_polys('0);
        build_expected();
        start_run('0, '0);
        wait_done();
        compare_results("edge", '0);
    endtask

    task automatic test_random();
        fill_random_polys();
        load_polys('0);
        build_expected();
        start_run('0, '0);
        wait_done();
        compare_results("random", '0);
    endtask

    // destination base wraps past the top of the sk address space
    task automatic test_bases();
        fill_random_polys();
        load_polys(mem_addr_t'(161));
        build_expected();
        start_run(mem_addr_t'(161), sk_addr_t'(12'hf40));
        wait_done();
        compare_results("bases", sk_addr_t'(12'hf40));
    endtask

    task automatic test_zeroize();
        int n;
        fill_random_polys();
        load_polys('0);
        build_expected();
        start_run('0, '0);
        n = 0;
        while (ska_data_q.size() < 10 && n < RUN_LIMIT) begin
            drive_step();
            n++;
        end
        if (ska_data_q.size() < 10) begin
            report_failure("no sk words appeared before the zeroize point");
        end
        zeroize = 1'b1;
        drive_step();
        zeroize = 1'b0;
        clear_captures();
        repeat (30) drive_step();
        if (pk_data_q.size() != 0 || ska_data_q.size() != 0 || done_cnt != 0) begin
            report_failure("outputs kept writing after zeroize");
        end
        start_run('0, '0);
        wait_done();
        compare_results("zeroize_rerun", '0);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(32'h981));
        reset_n = 1'b0;
        zeroize = 1'b0;
        enable = 1'b0;
        src_base_addr = '0;
        skmem_dest_base_addr = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        clear_captures();
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        test_idle();
        test_edge();
        test_random();
        test_bases();
        test_zeroize();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* src.f */
rtl/p2r_pkg.sv
rtl/power2round_lane.sv
rtl/sk_pack_buffer.sv
rtl/power2round_ctrl.sv
rtl/power2round_top.sv
rtl/coef_mem.sv
rtl/p2r_subsys.sv
dv/tb_p2r_subsys.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_p2r_subsys -o sim_p2r

output=$(./obj_dir/sim_p2r 2>&1) || { echo "$output"; exit 1; }
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
